//--- src.f
+incdir+src
src/sdmac_bus_pkg.sv
src/sdmac_reg_pkg.sv
src/sdmac_addr_decoder.sv
src/sdmac_cntr_reg.sv
src/sdmac_istr_reg.sv
src/sdmac_registers.sv
verification/tb_clk_gen.sv
verification/sdmac_registers_chk.sv
verification/tb_sdmac_checker.sv
verification/tb_sdmac.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_sdmac
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TB FAILED" $(LOG) || ! grep -q "TB PASSED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- verification/tb_sdmac.sv
// Testbench top for the SDMAC register block
// Falling-edge bus stimulus, register model and watchdog, the checker compares
`timescale 1ns/1ps
`default_nettype none
`include "sdmac_macros.svh"

module tb_sdmac;

  localparam int CLK_PERIOD = 100;
  localparam int WD_CYCLES  = 2000; // Test sequence needs a few hundred cycles

  logic                     clk;
  logic                     rst_n;
  sdmac_bus_pkg::bus_req_t  req;
  sdmac_bus_pkg::bus_rsp_t  rsp;
  logic                     stop_flush, fifo_empty, fifo_full, inta_i;
  logic                     flushfifo, a1, int_o_, dmadir, dmaena, preset, wd_req;
  logic [7:0]               m_cntr;   // Model CNTR bits
  logic                     m_dmaena, m_int_f, m_flush, m_a1;
  logic [31:0]              lfsr;
  sdmac_bus_pkg::bus_data_t exp_rdata;
  logic [5:0]               exp_ports;
  logic                     exp_wd, port_chk, test_done;
  logic [2:0]               test_id;
  int                       check_count, err_count;
  int                       tb_errors; // Missing handshakes

  assign exp_ports = {m_flush, m_a1, ~(m_int_f & m_cntr[`CNTR_INTENA_BIT]),
                      m_cntr[`CNTR_DMADIR_BIT], m_dmaena, m_cntr[`CNTR_PRESET_BIT]};

  tb_clk_gen #(.PERIOD (CLK_PERIOD), .RST_CYCLES (8)) i_clk_gen (.clk (clk), .rst_n (rst_n));

  sdmac_registers i_sdmac_registers (
    .ACR_WR (clk), .RST_ (rst_n), .req (req), .rsp (rsp), .stop_flush (stop_flush),
    .fifo_empty (fifo_empty), .fifo_full (fifo_full), .inta_i (inta_i),
    .flushfifo (flushfifo), .a1 (a1), .int_o_ (int_o_), .dmadir (dmadir),
    .dmaena (dmaena), .preset (preset), .wd_req (wd_req)
  );

  tb_sdmac_checker i_checker (
    .ACR_WR (clk), .rsp (rsp), .wd_req (wd_req),
    .dut_ports ({flushfifo, a1, int_o_, dmadir, dmaena, preset}), .exp_ports (exp_ports),
    .exp_wd (exp_wd), .exp_rdata (exp_rdata), .port_chk (port_chk),
    .test_done (test_done), .test_id (test_id), .check_count (check_count),
    .err_count (err_count)
  );

  bind sdmac_registers sdmac_registers_chk i_regs_chk (
    .ACR_WR (ACR_WR), .RST_ (RST_), .req (req), .rsp (rsp), .intena (intena),
    .int_o_ (int_o_), .dmaena (dmaena), .flushfifo (flushfifo)
  );

  // Galois LFSR, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic sdmac_bus_pkg::bus_data_t rand_word();
    sdmac_bus_pkg::bus_data_t w;
    for (int i = 0; i < 32; i++) begin
      w[i] = lfsr[0];  // One step per bit
      lfsr = lfsr_step(lfsr);
    end
    return w;
  endfunction

  // Applies one access to the model, returns what a read gives back
  function automatic sdmac_bus_pkg::bus_data_t model_read(input logic rw,
      input sdmac_bus_pkg::bus_addr_t addr, input sdmac_bus_pkg::bus_data_t wd);
    sdmac_bus_pkg::bus_data_t r;
    r = '0;
    if (rw) begin
      case (addr)
        `SDMAC_WTC_ADR:  r = `SDMAC_WTC_VALUE;
        `SDMAC_CNTR_ADR: r = {23'd0, m_dmaena, m_cntr};
        `SDMAC_ISTR_ADR: begin
          r[`ISTR_FE_BIT]    = fifo_empty; // Live flags
          r[`ISTR_FF_BIT]    = fifo_full;
          r[`ISTR_INT_P_BIT] = m_int_f & m_cntr[`CNTR_INTENA_BIT];
          r[`ISTR_INT_F_BIT] = m_int_f;
        end
        default: r = '0; // ACR, window, unmapped
      endcase
    end else begin
      case (addr)
        `SDMAC_CNTR_ADR:    m_cntr = wd[7:0];
        `SDMAC_ACR_ADR:     m_a1 = wd[`ACR_A1_BIT];
        `SDMAC_ST_DMA_ADR:  m_dmaena = 1'b1;
        `SDMAC_SP_DMA_ADR:  m_dmaena = 1'b0;
        `SDMAC_CLR_INT_ADR: m_int_f = 1'b0;
        `SDMAC_FLUSH_ADR:   m_flush = 1'b1;
        default: ;
      endcase
    end
    return r;
  endfunction

  // One strobe cycle, wd_req expected in the next
  task automatic bus_access(input logic rw, input sdmac_bus_pkg::bus_addr_t addr,
                            input sdmac_bus_pkg::bus_data_t wd);
    req = '{strobe: 1'b1, rw: rw, addr: addr, wdata: wd};
    @(negedge clk);
    req    = '0;
    exp_wd = (addr >= `SDMAC_WD_BASE) && (addr < `SDMAC_WD_BASE + 8'd16);
    @(negedge clk);
    exp_wd = 1'b0;
  endtask

  task automatic do_write(input sdmac_bus_pkg::bus_addr_t addr,
                          input sdmac_bus_pkg::bus_data_t wd);
    void'(model_read(1'b0, addr, wd));
    bus_access(1'b0, addr, wd);
    @(negedge clk); // int_o_ lags ISTR by one
  endtask

  task automatic do_read(input sdmac_bus_pkg::bus_addr_t addr);
    int n;
    n = 0;
    exp_rdata = model_read(1'b1, addr, '0);
    bus_access(1'b1, addr, '0);
    while (!rsp.rd_valid && n < 8) begin
      @(negedge clk);
      n++;
    end
    if (!rsp.rd_valid) begin
      $display("Read of address %h got no rd_valid within 8 cycles", addr);
      tb_errors++;
    end
    @(negedge clk); // Hold exp_rdata until the checker samples
  endtask

  task automatic pulse_inta();
    inta_i = 1'b1;
    @(negedge clk);
    inta_i  = 1'b0;
    m_int_f = 1'b1;
    @(negedge clk);
  endtask

  task automatic pulse_stop_flush();
    stop_flush = 1'b1;
    @(negedge clk);
    stop_flush = 1'b0;
    m_flush    = 1'b0;
  endtask

  task automatic check_ports();
    port_chk = 1'b1;
    @(negedge clk);
    port_chk = 1'b0;
  endtask

  task automatic finish_test();
    test_done = 1'b1;
    @(negedge clk);
    test_done = 1'b0;
  endtask

  initial begin
    #(WD_CYCLES * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles, run did not finish", WD_CYCLES);
    $display("TB FAILED");
    $finish;
  end

  initial begin
    req        = '0;
    stop_flush = 1'b0;
    fifo_empty = 1'b1;
    fifo_full  = 1'b0;
    inta_i     = 1'b0;
    {m_cntr, m_dmaena, m_int_f, m_flush, m_a1} = '0;
    lfsr       = 32'h4842;
    exp_rdata  = '0;
    {exp_wd, port_chk, test_done} = '0;
    test_id    = 3'd0;
    tb_errors  = 0;
    @(posedge rst_n);
    @(negedge clk);
    check_ports();
    do_read(`SDMAC_CNTR_ADR);
    do_read(`SDMAC_ISTR_ADR);
    finish_test();
    test_id = 3'd1;
    repeat (4) begin
      do_write(`SDMAC_CNTR_ADR, rand_word());
      check_ports();
      do_read(`SDMAC_CNTR_ADR);
    end
    do_read(`SDMAC_WTC_ADR);
    do_read(8'h20);          // Unmapped
    do_read(`SDMAC_ACR_ADR); // Write only
    finish_test();
    test_id = 3'd2;
    do_write(`SDMAC_ST_DMA_ADR, rand_word());
    check_ports();
    do_read(`SDMAC_CNTR_ADR);
    do_write(`SDMAC_SP_DMA_ADR, rand_word());
    check_ports();
    do_read(`SDMAC_CNTR_ADR);
    finish_test();
    test_id = 3'd3;
    do_write(`SDMAC_CNTR_ADR, rand_word() | 32'h4); // intena on
    pulse_inta();
    check_ports();
    fifo_empty = 1'b0;
    fifo_full  = 1'b1;
    do_read(`SDMAC_ISTR_ADR);
    do_write(`SDMAC_CLR_INT_ADR, '0);
    check_ports();
    do_read(`SDMAC_ISTR_ADR);
    do_write(`SDMAC_CNTR_ADR, rand_word() & ~32'h4); // Only int_f may set
    pulse_inta();
    check_ports();
    do_read(`SDMAC_ISTR_ADR);
    do_write(`SDMAC_CLR_INT_ADR, '0);
    do_read(`SDMAC_ISTR_ADR);
    fifo_empty = 1'b1;
    fifo_full  = 1'b0;
    finish_test();
    test_id = 3'd4;
    do_write(`SDMAC_FLUSH_ADR, '0);
    check_ports();
    pulse_stop_flush();
    check_ports();
    do_write(`SDMAC_ACR_ADR, rand_word() | 32'h0200_0000);
    check_ports();
    do_write(`SDMAC_ACR_ADR, rand_word() & ~32'h0200_0000);
    check_ports();
    do_write(`SDMAC_WD_BASE, rand_word());
    do_read(`SDMAC_WD_BASE + 8'h4); // Chip data not modelled, reads 0
    check_ports();
    finish_test();
    $display("Checks: %0d, errors: %0d, handshake failures: %0d", check_count, err_count,
             tb_errors);
    if (err_count == 0 && tb_errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verification/tb_sdmac_checker.sv
// Compares DUT outputs of the SDMAC testbench with the model's expected values
// Samples on rising edges, where the falling-edge stimulus has settled
`timescale 1ns/1ps
`default_nettype none

module tb_sdmac_checker (
  input  wire                           ACR_WR,
  input  wire sdmac_bus_pkg::bus_rsp_t  rsp,
  input  wire                           wd_req,
  input  wire [5:0]                     dut_ports, // flush, a1, int_o_, dir, ena, preset
  input  wire [5:0]                     exp_ports,
  input  wire                           exp_wd,
  input  wire sdmac_bus_pkg::bus_data_t exp_rdata,
  input  wire                           port_chk,  // Compare ports this cycle
  input  wire                           test_done,
  input  wire [2:0]                     test_id,
  output int                            check_count,
  output int                            err_count
);

  int checks = 0;
  int errs = 0;
  int test_errs = 0; // Errors in the running test

  assign check_count = checks;
  assign err_count   = errs;

  function automatic string test_name(input logic [2:0] id);
    case (id)
      3'd0:    return "reset_values";
      3'd1:    return "cntr_readback";
      3'd2:    return "dma_start_stop";
      3'd3:    return "interrupts";
      3'd4:    return "flush_a1_window";
      default: return "unknown";
    endcase
  endfunction

  always @(posedge ACR_WR) begin
    if (rsp.rd_valid) begin
      checks++;
      if (rsp.rdata !== exp_rdata) begin
        $display("[FAIL] %s rdata: expected %h, actual %h", test_name(test_id), exp_rdata,
                 rsp.rdata);
        errs++;
        test_errs++;
      end
    end
    if (exp_wd) checks++;
    if (wd_req !== exp_wd) begin // Pulse must sit in exactly one cycle
      $display("[FAIL] %s wd_req: expected %b, actual %b", test_name(test_id), exp_wd, wd_req);
      errs++;
      test_errs++;
    end
    if (port_chk) begin
      checks++;
      if (dut_ports !== exp_ports || rsp !== '0) begin
        $display("[FAIL] %s ports: expected %b rsp 0, actual %b rsp %h", test_name(test_id),
                 exp_ports, dut_ports, rsp);
        errs++;
        test_errs++;
      end
    end
    if (test_done) begin
      $display("Test %s finished, %0d errors", test_name(test_id), test_errs);
      test_errs = 0;
    end
  end

endmodule

`default_nettype wire

//--- verification/sdmac_registers_chk.sv
// Protocol assertions for the SDMAC register block, bound into sdmac_registers
`timescale 1ns/1ps
`default_nettype none

module sdmac_registers_chk (
  input wire                          ACR_WR,
  input wire                          RST_,
  input wire sdmac_bus_pkg::bus_req_t req,
  input wire sdmac_bus_pkg::bus_rsp_t rsp,
  input wire                          intena,
  input wire                          int_o_,
  input wire                          dmaena,
  input wire                          flushfifo
);

  logic seen_strobe; // Any access since reset

  always_ff @(posedge ACR_WR or negedge RST_) begin
    if (!RST_) seen_strobe <= 1'b0;
    else if (req.strobe) seen_strobe <= 1'b1;
  end

  // Response only for a read two edges back
  rd_valid_src: assert property (@(posedge ACR_WR) disable iff (!RST_)
    rsp.rd_valid |-> $past(req.strobe & req.rw, 2))
    else $error("rd_valid without a read strobe two cycles earlier");

  // Output register lags intena by one edge
  int_needs_ena: assert property (@(posedge ACR_WR) disable iff (!RST_)
    !int_o_ |-> $past(intena))
    else $error("int_o_ low while interrupts were disabled");

  idle_after_rst: assert property (@(posedge ACR_WR) disable iff (!RST_)
    !seen_strobe |-> (!dmaena && !flushfifo))
    else $error("dmaena or flushfifo active before the first access");

endmodule

`default_nettype wire

//--- verification/tb_clk_gen.sv
// Clock and reset source for the SDMAC testbench
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD     = 100, // ns
  parameter int RST_CYCLES = 8
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  initial begin
    rst_n = 1'b0;
    #(PERIOD * RST_CYCLES) rst_n = 1'b1; // Release lands on a falling edge
  end

endmodule

`default_nettype wire

//--- src/sdmac_registers.sv
// SDMAC register block top, decoder, CNTR, ISTR, read mux, flush latch and A1
// Reads answer two cycles after the strobe with a single rd_valid pulse
`timescale 1ns/1ps
`default_nettype none
`include "sdmac_macros.svh"

module sdmac_registers (
  input  wire                          ACR_WR,     // System clock
  input  wire                          RST_,
  input  wire sdmac_bus_pkg::bus_req_t req,
  output sdmac_bus_pkg::bus_rsp_t      rsp,
  input  wire                          stop_flush,
  input  wire                          fifo_empty,
  input  wire                          fifo_full,
  input  wire                          inta_i,
  output logic                         flushfifo,
  output logic                         a1,
  output logic                         int_o_,
  output logic                         dmadir,
  output logic                         dmaena,
  output logic                         preset,
  output logic                         wd_req
);

  sdmac_reg_pkg::reg_sel_e   sel;
  sdmac_reg_pkg::action_t    act;
  sdmac_reg_pkg::reg9_t      cntr_image;
  sdmac_reg_pkg::reg9_t      istr_image;
  logic                      intena;
  logic                      rd_q;      // Read in flight, aligned with sel
  sdmac_bus_pkg::bus_data_t  wdata_q;   // Write data, aligned with act
  sdmac_bus_pkg::bus_data_t  rdata_mux;

  sdmac_addr_decoder i_addr_decoder (
    .ACR_WR (ACR_WR), .RST_ (RST_), .req (req),
    .sel (sel), .act (act), .wd_req (wd_req)
  );

  sdmac_cntr_reg i_cntr_reg (
    .ACR_WR (ACR_WR), .RST_ (RST_), .act (act), .wdata (wdata_q),
    .cntr_image (cntr_image), .dmadir (dmadir), .dmaena (dmaena),
    .intena (intena), .preset (preset)
  );

  sdmac_istr_reg i_istr_reg (
    .ACR_WR (ACR_WR), .RST_ (RST_), .clr_int (act.clr_int), .intena (intena),
    .fifo_empty (fifo_empty), .fifo_full (fifo_full), .inta_i (inta_i),
    .istr_image (istr_image), .int_o_ (int_o_)
  );

  // Request copy, one stage to line up with the decoder
  always_ff @(posedge ACR_WR or negedge RST_) begin
    if (!RST_) rd_q <= 1'b0;
    else       rd_q <= req.strobe & req.rw;
  end

  always_ff @(posedge ACR_WR) begin
    wdata_q <= req.wdata;
  end

  always_comb begin
    case (sel)
      sdmac_reg_pkg::SEL_WTC:  rdata_mux = `SDMAC_WTC_VALUE;
      sdmac_reg_pkg::SEL_CNTR: rdata_mux = {23'd0, cntr_image};
      sdmac_reg_pkg::SEL_ISTR: rdata_mux = {23'd0, istr_image};
      default:                 rdata_mux = '0; // ACR, window, unmapped
    endcase
  end

  // Image sampled before this cycle's register updates land
  always_ff @(posedge ACR_WR or negedge RST_) begin
    if (!RST_) begin
      rsp <= '0;
    end else begin
      rsp.rd_valid <= rd_q;
      rsp.rdata    <= rdata_mux; // sel is SEL_NONE unless a read is in flight
    end
  end

  // Flush latch, stop_flush has priority
  always_ff @(posedge ACR_WR or negedge RST_) begin
    if (!RST_)          flushfifo <= 1'b0;
    else if (stop_flush) flushfifo <= 1'b0;
    else if (act.flush)  flushfifo <= 1'b1;
  end

  // A1 from ACR writes
  always_ff @(posedge ACR_WR or negedge RST_) begin
    if (!RST_)          a1 <= 1'b0;
    else if (act.acr_wr) a1 <= wdata_q[`ACR_A1_BIT];
  end

endmodule

`default_nettype wire

//--- src/sdmac_istr_reg.sv
// SDMAC interrupt status register and the active-low interrupt output
// FIFO flags pass straight into the image, interrupt flags are latched
`timescale 1ns/1ps
`default_nettype none
`include "sdmac_macros.svh"

module sdmac_istr_reg (
  input  wire                  ACR_WR,
  input  wire                  RST_,
  input  wire                  clr_int,    // Write to CLR_INT
  input  wire                  intena,     // From CNTR
  input  wire                  fifo_empty,
  input  wire                  fifo_full,
  input  wire                  inta_i,     // Interrupt from SCSI chip
  output sdmac_reg_pkg::reg9_t istr_image,
  output logic                 int_o_      // Interrupt to CPU, active low
);

  logic int_f; // Interrupt follow, raw latch
  logic int_p; // Interrupt pending, enabled

  // Set wins over clear while inta_i still high
  always_ff @(posedge ACR_WR or negedge RST_) begin
    if (!RST_) begin
      int_f <= 1'b0;
    end else if (inta_i) begin
      int_f <= 1'b1;
    end else if (clr_int) begin
      int_f <= 1'b0;
    end
  end

  assign int_p = int_f & intena;

  // Image, unused bits read 0
  always_comb begin
    istr_image                  = '0;
    istr_image[`ISTR_FE_BIT]    = fifo_empty; // Live flag
    istr_image[`ISTR_FF_BIT]    = fifo_full;  // Live flag
    istr_image[`ISTR_INT_P_BIT] = int_p;
    istr_image[`ISTR_INT_F_BIT] = int_f;
  end

  // Registered output, one cycle behind int_p
  always_ff @(posedge ACR_WR or negedge RST_) begin
    if (!RST_) begin
      int_o_ <= 1'b1;
    end else begin
      int_o_ <= ~int_p;
    end
  end

endmodule

`default_nettype wire

//--- src/sdmac_cntr_reg.sv
// SDMAC control register, CNTR bits plus the DMA enable flag
// Loaded from the delayed write data on the decoder's cntr_wr strobe
`timescale 1ns/1ps
`default_nettype none
`include "sdmac_macros.svh"

module sdmac_cntr_reg (
  input  wire                           ACR_WR,
  input  wire                           RST_,
  input  wire sdmac_reg_pkg::action_t   act,
  input  wire sdmac_bus_pkg::bus_data_t wdata,      // Aligned with act
  output sdmac_reg_pkg::reg9_t          cntr_image,
  output logic                          dmadir,
  output logic                          dmaena,
  output logic                          intena,
  output logic                          preset
);

  logic [7:0] cntr_q; // Written CNTR bits

  always_ff @(posedge ACR_WR or negedge RST_) begin
    if (!RST_) begin
      cntr_q <= '0;
    end else if (act.cntr_wr) begin
      cntr_q <= wdata[7:0];
    end
  end

  // DMA enable, stop has priority over start
  always_ff @(posedge ACR_WR or negedge RST_) begin
    if (!RST_) begin
      dmaena <= 1'b0;
    end else if (act.sp_dma) begin
      dmaena <= 1'b0;
    end else if (act.st_dma) begin
      dmaena <= 1'b1;
    end
  end

  // Readback image, dmaena shows in bit 8
  assign cntr_image = {dmaena, cntr_q};

  assign dmadir = cntr_q[`CNTR_DMADIR_BIT]; // 1 = to SCSI
  assign intena = cntr_q[`CNTR_INTENA_BIT]; // Gates int_p
  assign preset = cntr_q[`CNTR_PRESET_BIT]; // Peripheral reset

endmodule

`default_nettype wire

//--- src/sdmac_addr_decoder.sv
// Address decoder, turns one bus request into a read select and write action strobes
// All outputs are registered, valid the cycle after the strobe
`timescale 1ns/1ps
`default_nettype none
`include "sdmac_macros.svh"

module sdmac_addr_decoder (
  input  wire                     ACR_WR, // System clock
  input  wire                     RST_,
  input  wire sdmac_bus_pkg::bus_req_t req,
  output sdmac_reg_pkg::reg_sel_e sel,
  output sdmac_reg_pkg::action_t  act,
  output logic                    wd_req  // SCSI chip window access
);

  logic                    rd;
  logic                    wr;
  logic                    in_wd;
  sdmac_reg_pkg::reg_sel_e sel_d;
  sdmac_reg_pkg::action_t  act_d;

  assign rd    = req.strobe & req.rw;
  assign wr    = req.strobe & ~req.rw;
  assign in_wd = (req.addr & `SDMAC_WD_MASK) == `SDMAC_WD_BASE; // 0x40..0x4F

  always_comb begin
    sel_d = sdmac_reg_pkg::SEL_NONE;
    act_d = '0;
    // Reads only pick an image
    if (rd) begin
      case (req.addr)
        `SDMAC_WTC_ADR:  sel_d = sdmac_reg_pkg::SEL_WTC;
        `SDMAC_CNTR_ADR: sel_d = sdmac_reg_pkg::SEL_CNTR;
        `SDMAC_ISTR_ADR: sel_d = sdmac_reg_pkg::SEL_ISTR;
        `SDMAC_ACR_ADR:  sel_d = sdmac_reg_pkg::SEL_ACR;
        default: begin
          if (in_wd) sel_d = sdmac_reg_pkg::SEL_WD;
        end
      endcase
    end
    // Action offsets respond to writes only
    if (wr) begin
      case (req.addr)
        `SDMAC_CNTR_ADR:    act_d.cntr_wr = 1'b1;
        `SDMAC_ACR_ADR:     act_d.acr_wr  = 1'b1;
        `SDMAC_ST_DMA_ADR:  act_d.st_dma  = 1'b1;
        `SDMAC_SP_DMA_ADR:  act_d.sp_dma  = 1'b1;
        `SDMAC_CLR_INT_ADR: act_d.clr_int = 1'b1;
        `SDMAC_FLUSH_ADR:   act_d.flush   = 1'b1;
        default: ; // Read-only or unmapped, ignored
      endcase
    end
  end

  always_ff @(posedge ACR_WR or negedge RST_) begin
    if (!RST_) begin
      sel    <= sdmac_reg_pkg::SEL_NONE;
      act    <= '0;
      wd_req <= 1'b0;
    end else begin
      sel    <= sel_d;
      act    <= act_d;                // Strobes last one cycle
      wd_req <= req.strobe & in_wd;   // Reads and writes alike
    end
  end

endmodule

`default_nettype wire

//--- src/sdmac_reg_pkg.sv
// Register field types of the SDMAC register block
// Decoder select, action strobes and 9-bit register images
`default_nettype none

package sdmac_reg_pkg;

  // CNTR and ISTR images are both 9 bits wide
  typedef logic [8:0] reg9_t;

  // Which image a read returns
  typedef enum logic [2:0] {
    SEL_NONE = 3'd0, // Write, unmapped or write-only read
    SEL_WTC  = 3'd1,
    SEL_CNTR = 3'd2,
    SEL_ISTR = 3'd3,
    SEL_ACR  = 3'd4, // Write-only, reads give 0
    SEL_WD   = 3'd5  // SCSI chip window, data from the chip
  } reg_sel_e;

  // One-cycle action strobes from register writes
  typedef struct packed {
    logic st_dma;  // Start DMA
    logic sp_dma;  // Stop DMA
    logic clr_int; // Clear interrupts
    logic flush;   // Flush FIFO
    logic cntr_wr; // Load CNTR
    logic acr_wr;  // Load ACR, A1 capture
  } action_t;

endpackage

`default_nettype wire

//--- src/sdmac_bus_pkg.sv
// CPU bus transfer types shared by the SDMAC register block and its testbench
// Referenced by scoped name only
`default_nettype none

package sdmac_bus_pkg;

  // Low address byte, the block decodes nothing above it
  typedef logic [7:0] bus_addr_t;

  // CPU data word
  typedef logic [31:0] bus_data_t;

  // Single cycle access, valid only while strobe is high
  typedef struct packed {
    logic      strobe; // Access strobe, no back-pressure
    logic      rw;     // 1 = read, 0 = write
    bus_addr_t addr;
    bus_data_t wdata;
  } bus_req_t;         // 42 bits

  // Registered answer, one cycle after decode
  typedef struct packed {
    logic      rd_valid; // Single pulse per read
    bus_data_t rdata;    // Zero when rd_valid low
  } bus_rsp_t;           // 33 bits

endpackage

`default_nettype wire

//--- src/sdmac_macros.svh
// Register map, field positions and fixed read values of the SDMAC register block
// Included by every RTL file that decodes addresses or picks register bits
`ifndef SDMAC_MACROS_SVH
`define SDMAC_MACROS_SVH

`define SDMAC_WTC_ADR     8'h04 // Word transfer count, read only
`define SDMAC_CNTR_ADR    8'h08 // Control register
`define SDMAC_ACR_ADR     8'h0C // Address control, write only here
`define SDMAC_ST_DMA_ADR  8'h10 // Start DMA strobe
`define SDMAC_FLUSH_ADR   8'h14 // Flush FIFO strobe
`define SDMAC_CLR_INT_ADR 8'h18 // Clear interrupts strobe
`define SDMAC_ISTR_ADR    8'h1C // Interrupt status
`define SDMAC_SP_DMA_ADR  8'h3C // Stop DMA strobe
`define SDMAC_WD_BASE     8'h40 // SCSI chip window, 16 bytes
`define SDMAC_WD_MASK     8'hF0

`define SDMAC_WTC_VALUE   32'h0000_0004

`define CNTR_DMADIR_BIT 1
`define CNTR_INTENA_BIT 2
`define CNTR_PRESET_BIT 4

`define ISTR_FE_BIT    0
`define ISTR_FF_BIT    1
`define ISTR_INT_P_BIT 4
`define ISTR_INT_F_BIT 5

`define ACR_A1_BIT 25 // Write data bit latched into A1

`endif
